/* files.f */
+incdir+design
design/snd_pkg.sv
design/snd_bus_ctrl.sv
design/snd_cen_gen.sv
design/snd_ram.sv
design/snd_latch.sv
design/snd_mixer.sv
design/snd_top.sv
verification/snd_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sound board simulation with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module snd_tb -f files.f -o snd_tb_sim

./obj_dir/snd_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

/* verification/snd_tb.sv */
// testbench for snd_top with wishbone master tasks, rom model, directed tests and watchdog
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_tb;

    localparam int NUM_TESTS = 6;
    localparam int ACK_LIMIT = 50;      // cycles per bus access
    localparam int SMP_LIMIT = 200;     // cycles to wait for one sample pulse

    logic                   clk = 1'b0;
    logic                   rst;
    snd_pkg::wb_req_t       wb_req;
    snd_pkg::wb_rsp_t       wb_rsp;
    logic [`SND_ROM_AW-1:0] rom_addr;
    logic                   rom_cs;
    logic [`SND_DW-1:0]     rom_data;
    logic                   rom_ok;
    logic [`SND_DW-1:0]     snd_latch;
    logic                   snd_irq;
    logic                   nmi_n;
    logic signed [15:0]     fm_snd;
    logic signed [13:0]     adpcm_snd;
    logic signed [15:0]     sound;
    logic                   sample;

    int          err_cnt  = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    logic [31:0] lfsr     = 32'h6a83;

    snd_top snd_top_inst (.*);

    always #4 clk = ~clk;               // 8 ns period

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};      // taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] r);
        r = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[14:0], lfsr[31]};                     // one step per bit
        end
    endtask

    // every address bit reaches the byte
    function automatic logic [7:0] rom_byte(input logic [14:0] a);
        return a[7:0] ^ {a[14:8], 1'b1} ^ 8'hA5;
    endfunction

    // adpcm x16 weighted 1.5 on top of fm, then the 4.4 gain and a clamp
    function automatic logic signed [15:0] mix_expect(input int fm, input int ad,
                                                      input logic [1:0] code);
        longint f;
        longint mix;
        longint scaled;
        case (code)
            2'd0:    f = `SND_GAIN_0;
            2'd1:    f = `SND_GAIN_1;
            2'd2:    f = `SND_GAIN_2;
            default: f = `SND_GAIN_3;
        endcase
        mix    = fm + 24 * ad;
        scaled = (mix * f) >>> 4;       // floors like dropping the fraction bits
        if (scaled > 32767)
            scaled = 32767;
        else if (scaled < -32768)
            scaled = -32768;
        return 16'(scaled);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        if (err_cnt == err_start) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - err_start);
        end
    endtask

    // classic cycle with the strobe held until ack and dropped after it
    task automatic wb_access(input logic [15:0] adr, input logic we,
                             input logic [7:0] wdat, output logic [7:0] rdat);
        int n;
        n    = 0;
        rdat = 8'h00;
        @(posedge clk);
        #1;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        wb_req.we  = we;
        wb_req.stb = 1'b1;
        do begin
            @(negedge clk);             // ack comes from a register and is stable here
            n++;
        end while (!wb_rsp.ack && n < ACK_LIMIT);
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat;
        end else begin
            err_cnt++;
            $display("no ack within %0d cycles for address %h", ACK_LIMIT, adr);
        end
        @(posedge clk);
        #1;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        wb_access(adr, 1'b1, dat, unused);
    endtask

    task automatic wb_read(input logic [15:0] adr, output logic [7:0] dat);
        wb_access(adr, 1'b0, 8'h00, dat);
    endtask

    // rom answers 0 to 3 cycles after it sees rom_cs
    initial begin
        logic [15:0] dly;
        forever begin
            @(posedge clk);
            if (rom_cs) begin
                rand_bits(2, dly);
                repeat (dly) @(posedge clk);
                #1;
                rom_data = rom_byte(rom_addr);
                rom_ok   = 1'b1;
                @(posedge clk);         // bus controller takes the byte here
                #1;
                rom_ok   = 1'b0;
            end
        end
    end

    // rom_cs only while an access is open
    always @(negedge clk) begin
        if (!rst && !wb_req.stb)
            check_eq("rom_cs", rom_cs, 0);
    end

    task automatic test_rom_reads();
        int          e0;
        logic [15:0] adr;
        logic [7:0]  d;
        e0 = err_cnt;
        for (int i = 0; i < 12; i++) begin
            adr = (i < 4) ? 16'(i * 16'h2AAA) : 16'((i * 16'h1357 + 16'h0F0F) & 16'h7FFF);
            if (i == 11)
                adr = 16'h7FFF;         // top of rom
            wb_read(adr, d);
            check_eq("rom read data", d, rom_byte(adr[14:0]));
        end
        end_test("rom_reads", e0);
    endtask

    task automatic test_ram_access();
        int         e0;
        logic [7:0] d;
        e0 = err_cnt;
        snd_latch = 8'h77;
        wb_write(16'h8000, 8'hA5);
        wb_write(16'h8001, 8'h3C);
        wb_write(16'h87FE, 8'hC3);
        wb_write(16'h87FF, 8'h5A);
        wb_write(16'h8800, 8'h11);     // unmapped and no ram alias
        wb_read(16'h8000, d);
        check_eq("ram 8000", d, 8'hA5);
        wb_read(16'h8001, d);
        check_eq("ram 8001", d, 8'h3C);
        wb_read(16'h87FE, d);
        check_eq("ram 87fe", d, 8'hC3);
        wb_read(16'h87FF, d);
        check_eq("ram 87ff", d, 8'h5A);
        wb_read(16'h8800, d);
        check_eq("unmapped 8800", d, 8'hFF);
        wb_read(16'hC000, d);
        check_eq("unmapped c000", d, 8'hFF);
        wb_write(16'h0010, 8'h00);     // rom is read only
        wb_read(16'h0010, d);
        check_eq("rom after write", d, rom_byte(15'h0010));
        wb_write(`SND_LATCH_ADR, 8'h99);
        wb_read(`SND_LATCH_ADR, d);
        check_eq("latch after write", d, 8'h77);
        end_test("ram_access", e0);
    endtask

    task automatic test_latch_nmi();
        int         e0;
        logic [7:0] d;
        e0 = err_cnt;
        @(posedge clk);
        #1;
        snd_latch = 8'h5C;
        @(negedge clk);
        check_eq("nmi_n idle", nmi_n, 1);
        @(posedge clk);
        #1;
        snd_irq = 1'b1;                 // command from the main cpu
        @(posedge clk);
        @(negedge clk);
        check_eq("nmi_n after irq edge", nmi_n, 0);
        wb_read(`SND_LATCH_ADR, d);
        check_eq("latch data", d, 8'h5C);
        @(negedge clk);
        check_eq("nmi_n after latch read", nmi_n, 1);
        @(posedge clk);
        #1;
        snd_irq = 1'b0;
        end_test("latch_nmi", e0);
    endtask

    task automatic test_gain_reg();
        int         e0;
        logic [7:0] d;
        e0 = err_cnt;
        wb_read(`SND_GAIN_ADR, d);
        check_eq("gain after reset", d, 8'h03);
        for (int c = 0; c < 4; c++) begin
            wb_write(`SND_GAIN_ADR, 8'hFC | 8'(c));        // upper bits not stored
            wb_read(`SND_GAIN_ADR, d);
            check_eq("gain readback", d, 32'(c));
        end
        end_test("gain_reg", e0);
    endtask

    task automatic wait_sample();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!sample && n < SMP_LIMIT);
        if (!sample) begin
            err_cnt++;
            $display("no sample pulse within %0d cycles", SMP_LIMIT);
        end
    endtask

    task automatic test_mixer();
        int   e0;
        int   fm_v[6]   = '{1000, 1000, -20000, 300, -7, -32768};
        int   ad_v[6]   = '{100, -50, -8000, 7, 0, 8191};
        logic [1:0] g_v[6] = '{2'd3, 2'd0, 2'd1, 2'd2, 2'd1, 2'd0};
        e0 = err_cnt;
        for (int i = 0; i < 6; i++) begin
            wb_write(`SND_GAIN_ADR, {6'd0, g_v[i]});
            fm_snd    = 16'(fm_v[i]);
            adpcm_snd = 14'(ad_v[i]);
            wait_sample();
            wait_sample();              // sound updates with the pulse
            check_eq("sound", 32'(sound), 32'(mix_expect(fm_v[i], ad_v[i], g_v[i])));
        end
        end_test("mixer", e0);
    endtask

    task automatic test_sample_rate();
        int e0;
        int cnt;
        int exp_cnt;
        e0      = err_cnt;
        cnt     = 0;
        exp_cnt = 5000 * `SND_CEN_N / `SND_CEN_M;
        repeat (5000) begin
            @(negedge clk);
            if (sample)
                cnt++;
        end
        if (cnt < exp_cnt - 1 || cnt > exp_cnt + 1) begin
            err_cnt++;
            $display("[FAIL] sample count got %h expected %h plus or minus 1", cnt, exp_cnt);
        end
        end_test("sample_rate", e0);
    endtask

    // ends a stuck run after a span sized from the test count
    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", NUM_TESTS * 2000);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        wb_req    = '0;
        rom_data  = '0;
        rom_ok    = 1'b0;
        snd_latch = '0;
        snd_irq   = 1'b0;
        fm_snd    = '0;
        adpcm_snd = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_rom_reads();
        test_ram_access();
        test_latch_nmi();
        test_gain_reg();
        test_mixer();
        test_sample_rate();
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* design/snd_top.sv */
// sound board top with bus controller, ram, latch, enable generator and mixer
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_top (
    input  logic                   clk,
    input  logic                   rst,
    // sound cpu bus
    input  snd_pkg::wb_req_t       wb_req,
    output snd_pkg::wb_rsp_t       wb_rsp,
    // external program rom
    output logic [`SND_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    input  logic [`SND_DW-1:0]     rom_data,
    input  logic                   rom_ok,
    // main cpu side
    input  logic [`SND_DW-1:0]     snd_latch,
    input  logic                   snd_irq,
    output logic                   nmi_n,
    // voices from the synth chips
    input  logic signed [15:0]     fm_snd,
    input  logic signed [13:0]     adpcm_snd,
    output logic signed [15:0]     sound,
    output logic                   sample
);

    snd_pkg::snd_sel_t   sel;
    snd_pkg::gain_code_t gain;
    logic [`SND_DW-1:0]  ram_dout;
    logic [`SND_DW-1:0]  latch_dout;
    logic                cen_mix;

    snd_bus_ctrl snd_bus_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .sel        (sel),
        .ram_dout   (ram_dout),
        .latch_dout (latch_dout),
        .gain       (gain)
    );

    snd_ram snd_ram_inst (
        .clk  (clk),
        .sel  (sel),
        .we   (wb_req.we),
        .addr (wb_req.adr[`SND_RAM_AW-1:0]),
        .din  (wb_req.dat),
        .dout (ram_dout)
    );

    snd_latch snd_latch_inst (
        .clk       (clk),
        .rst       (rst),
        .sel       (sel),
        .rd_ack    (wb_rsp.ack && !wb_req.we),     // reads only
        .snd_latch (snd_latch),
        .snd_irq   (snd_irq),
        .dout      (latch_dout),
        .nmi_n     (nmi_n)
    );

    snd_cen_gen snd_cen_gen_inst (
        .clk (clk),
        .rst (rst),
        .cen (cen_mix)
    );

    snd_mixer snd_mixer_inst (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen_mix),
        .gain      (gain),
        .fm_snd    (fm_snd),
        .adpcm_snd (adpcm_snd),
        .sound     (sound),
        .sample    (sample)
    );

endmodule

/* design/snd_mixer.sv */
// fm and adpcm voice mix with gain, saturation and sample strobe
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_mixer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  snd_pkg::gain_code_t  gain,
    input  logic signed [15:0]   fm_snd,
    input  logic signed [13:0]   adpcm_snd,
    output logic signed [15:0]   sound,
    output logic                 sample
);

    localparam int SUM_W  = 20;
    localparam int PROD_W = SUM_W + 9;          // times signed 9-bit gain
    localparam int SCL_W  = PROD_W - 4;
    localparam logic signed [SCL_W-1:0] MAX_S = 32767;
    localparam logic signed [SCL_W-1:0] MIN_S = -32768;

    logic signed [17:0]       adpcm_ext;        // adpcm << 4
    logic signed [SUM_W-1:0]  mix_sum;
    logic        [7:0]        gain_f;           // 4.4 factor
    logic signed [PROD_W-1:0] prod;
    logic signed [SCL_W-1:0]  scaled;
    logic signed [15:0]       sat;

    assign adpcm_ext = {adpcm_snd, 4'd0};
    // adpcm weighted 1.5x against fm
    assign mix_sum   = fm_snd + adpcm_ext + (adpcm_ext >>> 1);

    always_comb begin
        case (gain)
            2'd0:    gain_f = `SND_GAIN_0;
            2'd1:    gain_f = `SND_GAIN_1;
            2'd2:    gain_f = `SND_GAIN_2;
            default: gain_f = `SND_GAIN_3;
        endcase
    end

    assign prod   = mix_sum * $signed({1'b0, gain_f});
    assign scaled = prod[PROD_W-1:4];           // drop the 4 fraction bits

    always_comb begin
        if (scaled > MAX_S)
            sat = 16'sh7FFF;
        else if (scaled < MIN_S)
            sat = -16'sh8000;
        else
            sat = scaled[15:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sound  <= '0;
            sample <= 1'b0;
        end else begin
            sample <= cen;                      // aligned with the new sound
            if (cen)
                sound <= sat;
        end
    end

endmodule

/* design/snd_latch.sv */
// main cpu command latch and edge-set nmi flag
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_latch (
    input  logic               clk,
    input  logic               rst,
    input  snd_pkg::snd_sel_t  sel,
    input  logic               rd_ack,      // acked read cycle
    input  logic [`SND_DW-1:0] snd_latch,
    input  logic               snd_irq,
    output logic [`SND_DW-1:0] dout,
    output logic               nmi_n
);

    logic irq_q;
    logic irq_edge;
    logic nmi_flag;
    logic clr;

    assign irq_edge = snd_irq && !irq_q;
    assign clr      = rd_ack && sel.latch;

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_q    <= 1'b0;
            nmi_flag <= 1'b0;
        end else begin
            irq_q <= snd_irq;
            if (irq_edge)
                nmi_flag <= 1'b1;       // new command wins over the clear
            else if (clr)
                nmi_flag <= 1'b0;
        end
    end

    assign nmi_n = !nmi_flag;
    assign dout  = snd_latch;           // main cpu side holds the value

    // reading the command acknowledges the nmi
    a_nmi_clear: assert property (@(posedge clk) disable iff (rst)
        (clr && !irq_edge) |=> nmi_n);

endmodule

/* design/snd_ram.sv */
// 2 KiB sound cpu work ram with registered read
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_ram (
    input  logic                   clk,
    input  snd_pkg::snd_sel_t      sel,
    input  logic                   we,
    input  logic [`SND_RAM_AW-1:0] addr,
    input  logic [`SND_DW-1:0]     din,
    output logic [`SND_DW-1:0]     dout
);

    localparam int DEPTH = 2 ** `SND_RAM_AW;

    logic [`SND_DW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (sel.ram && we)
            mem[addr] <= din;   // rewritten while the strobe is held, same value
        dout <= mem[addr];      // ready by the ack cycle
    end

endmodule

/* design/snd_cen_gen.sv */
// fractional n-over-m clock enable for the mixer
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_cen_gen (
    input  logic clk,
    input  logic rst,
    output logic cen
);

    localparam int ACC_W = $clog2(`SND_CEN_M + `SND_CEN_N);

    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] acc_nx;   // acc + n, before the wrap

    assign acc_nx = acc + ACC_W'(`SND_CEN_N);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
            cen <= 1'b0;
        end else if (acc_nx >= ACC_W'(`SND_CEN_M)) begin
            acc <= acc_nx - ACC_W'(`SND_CEN_M);       // keep the remainder
            cen <= 1'b1;
        end else begin
            acc <= acc_nx;
            cen <= 1'b0;
        end
    end

    // n below m/2 means a wrap can never follow a wrap
    a_cen_gap: assert property (@(posedge clk) disable iff (rst)
        cen |=> !cen);

endmodule

/* design/snd_bus_ctrl.sv */
// wishbone slave fsm with address decode, rom wait states, read mux and gain register
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_bus_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  snd_pkg::wb_req_t       wb_req,
    output snd_pkg::wb_rsp_t       wb_rsp,
    output logic [`SND_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    input  logic [`SND_DW-1:0]     rom_data,
    input  logic                   rom_ok,
    output snd_pkg::snd_sel_t      sel,
    input  logic [`SND_DW-1:0]     ram_dout,
    input  logic [`SND_DW-1:0]     latch_dout,
    output snd_pkg::gain_code_t    gain
);

    typedef enum logic [1:0] {
        st_idle,
        st_rom_wait,
        st_ack
    } state_t;

    state_t              state;
    logic [`SND_DW-1:0]  rom_q;     // rom byte captured on rom_ok
    logic [`SND_DW-1:0]  rd_mux;
    logic                is_ram;

    // 8000-87ff is the top bit set with the bits above the ram index clear
    assign is_ram = wb_req.adr[`SND_AW-1] &&
                    (wb_req.adr[`SND_AW-2:`SND_RAM_AW] == '0);

    always_comb begin
        sel = '0;
        if (wb_req.stb) begin
            if (!wb_req.adr[`SND_AW-1])
                sel.rom = 1'b1;                             // 0000-7fff
            else if (is_ram)
                sel.ram = 1'b1;
            else if (wb_req.adr == `SND_LATCH_ADR)
                sel.latch = 1'b1;
            else if (wb_req.adr == `SND_GAIN_ADR)
                sel.gain = 1'b1;
            else
                sel.none = 1'b1;
        end
    end

    assign rom_addr = wb_req.adr[`SND_ROM_AW-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            rom_cs <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (sel.rom) begin
                        state  <= st_rom_wait;
                        rom_cs <= 1'b1;                     // held until rom_ok
                    end else if (wb_req.stb) begin
                        state <= st_ack;                    // fixed 1 cycle latency
                    end
                end
                st_rom_wait: begin
                    if (rom_ok) begin
                        state  <= st_ack;
                        rom_cs <= 1'b0;
                    end
                end
                default: state <= st_idle;                  // ack lasts one cycle
            endcase
        end
    end

    // rom byte taken when rom_ok comes
    always_ff @(posedge clk) begin
        if (state == st_rom_wait && rom_ok)
            rom_q <= rom_data;
    end

    // gain register written in the ack cycle
    always_ff @(posedge clk) begin
        if (rst)
            gain <= 2'd3;                                   // loudest after reset
        else if (state == st_ack && sel.gain && wb_req.we)
            gain <= wb_req.dat[1:0];
    end

    always_comb begin
        case (1'b1)
            sel.rom:   rd_mux = rom_q;
            sel.ram:   rd_mux = ram_dout;
            sel.latch: rd_mux = latch_dout;
            sel.gain:  rd_mux = {6'd0, gain};
            sel.none:  rd_mux = 8'hFF;                      // unmapped reads
            default:   rd_mux = '0;                         // no access open
        endcase
    end

    assign wb_rsp.dat = rd_mux;
    assign wb_rsp.ack = (state == st_ack);

    // the fsm always passes through idle after an ack
    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack);

endmodule

/* design/snd_pkg.sv */
// wishbone request/response structs, decode select struct and gain code type
`include "snd_macros.svh"

package snd_pkg;

    // master to slave, cyc and stb merged into one strobe
    typedef struct packed {
        logic [`SND_AW-1:0] adr;
        logic [`SND_DW-1:0] dat;
        logic               we;
        logic               stb;    // cyc & stb
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic [`SND_DW-1:0] dat;
        logic               ack;
    } wb_rsp_t;

    // one-hot decode, all low while the strobe is low
    typedef struct packed {
        logic rom;
        logic ram;
        logic latch;
        logic gain;
        logic none;     // unmapped address
    } snd_sel_t;

    // volume code, picks one of four 4.4 factors
    typedef logic [1:0] gain_code_t;

endpackage

/* design/snd_macros.svh */
// address map, bus and memory widths, mixer enable ratio and gain factors
`ifndef SND_MACROS_SVH
`define SND_MACROS_SVH

// sound cpu bus
`define SND_AW        16
`define SND_DW        8

// memories behind the bus
`define SND_ROM_AW    15        // 32 KiB program rom, 0000-7fff
`define SND_RAM_AW    11        // 2 KiB work ram, 8000-87ff

// single-byte registers
`define SND_LATCH_ADR 16'hA000
`define SND_GAIN_ADR  16'hA800

// mixer cadence, n pulses every m clocks
`define SND_CEN_N     11
`define SND_CEN_M     500

// 4.4 fixed point volume factors
`define SND_GAIN_0    8'h18     // about 1.5x
`define SND_GAIN_1    8'h3F
`define SND_GAIN_2    8'h7F
`define SND_GAIN_3    8'hFF     // almost 16x

`endif
